//--- compile.f
+incdir+dv
source/dac_gen_pkg.sv
source/dac_gen_if.sv
source/dac_cfg_regs.sv
source/lane_lfsr.sv
source/tri_wave_gen.sv
source/pwl_segment_gen.sv
source/batch_out_pipe.sv
source/dac_sample_gen.sv
dv/tb_dac_sample_gen.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build output"

test:
	verilator --binary --timing --assert -Wno-fatal \
		--top-module tb_dac_sample_gen -f compile.f -o sim
	./obj_dir/sim | awk '{ print } /^Everything OK$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

//--- dv/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

function automatic logic [15:0] lfsr16_next(input logic [15:0] s);
	return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]}; // Taps 16, 14, 13, 11.
endfunction

// Lane i of batch k is its seed after k steps.
function automatic batch_t ref_lfsr_batch(input batch_t seeds, input int k);
	batch_t b;
	logic [15:0] s;
	for (int i = 0; i < LANES; i++) begin
		s = (seeds[i] == 16'h0) ? 16'h1 : seeds[i];
		for (int n = 0; n < k; n++) begin
			s = lfsr16_next(s);
		end
		b[i] = s;
	end
	return b;
endfunction

function automatic batch_t ref_tri_batch(input logic [15:0] step, input int k);
	batch_t b;
	logic [15:0] p;
	for (int i = 0; i < LANES; i++) begin
		p = 16'((k * LANES + i) * int'(step)); // Phase of sample k*LANES+i.
		b[i] = p[15] ? ~{p[14:0], 1'b0} : {p[14:0], 1'b0};
	end
	return b;
endfunction

// Segment and offset of sample n, counted from segment 0.
function automatic void ref_pwl_pos(input int n, output int seg, output int off);
	int last;
	seg = 0;
	off = 0;
	for (int k = 0; k < n; k++) begin
		last = (pwl_len[seg] == 16'h0) ? 0 : int'(pwl_len[seg]) - 1;
		if (off >= last) begin
			seg = (seg >= pwl_cnt) ? 0 : seg + 1;
			off = 0;
		end else begin
			off++;
		end
	end
endfunction

function automatic logic [15:0] ref_pwl_sample(input int n);
	int seg;
	int off;
	ref_pwl_pos(n, seg, off);
	return 16'(int'(pwl_start[seg]) + off * int'(pwl_slope[seg]));
endfunction

function automatic int ref_pwl_seg(input int n);
	int seg;
	int off;
	ref_pwl_pos(n, seg, off);
	return seg;
endfunction

function automatic batch_t ref_pwl_batch(input int k);
	batch_t b;
	for (int i = 0; i < LANES; i++) begin
		b[i] = ref_pwl_sample(k * LANES + i);
	end
	return b;
endfunction

function automatic logic [31:0] lfsr32_next(input logic [31:0] s);
	return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // Taps 32, 22, 2, 1.
endfunction

`endif

//--- dv/tb_dac_sample_gen.sv
`default_nettype none

module tb_dac_sample_gen;
	localparam int LANES = dac_gen_pkg::LANES;
	localparam int PIPE_DEPTH = 3;
	localparam int N_RAND = 64;
	localparam int N_TRI = 64;
	localparam int N_PWL = 14;
	localparam int N_RESTART = 16;
	localparam int TOTAL_BATCHES = N_RAND + 2 * N_TRI + N_PWL + 2 * N_RESTART;
	localparam int STALL_FACTOR = 4;
	localparam int MARGIN_CYCLES = 1000; // Reset and APB traffic.
	localparam int WATCHDOG_CYCLES = TOTAL_BATCHES * STALL_FACTOR + MARGIN_CYCLES;

	typedef dac_gen_pkg::sample_t [LANES-1:0] batch_t;

	logic clk;
	logic rst_n;
	dac_gen_pkg::apb_addr_t paddr;
	logic psel;
	logic penable;
	logic pwrite;
	dac_gen_pkg::apb_data_t pwdata;
	dac_gen_pkg::apb_data_t prdata;
	logic pready;
	logic pslverr;
	logic dac_rdy;
	batch_t dac_batch;
	logic dac_valid;

	logic [15:0] pwl_start [8];
	logic [15:0] pwl_slope [8];
	logic [15:0] pwl_len [8];
	int pwl_cnt;
	logic [31:0] rng_state;

	batch_t exp_q [$];
	logic check_en;
	logic hold_pending;
	logic held_valid;
	batch_t held_batch;
	int err_count = 0;
	int check_count = 0;
	int chk_errs = 0;
	int chk_count = 0;
	int tests_passed = 0;
	int tests_failed = 0;
	int test_err_start = 0;

	`include "tb_ref_model.svh"

	dac_sample_gen #(.NUM_LANES(LANES)) dac_sample_gen_inst (
		.clk(clk),
		.rst_n(rst_n),
		.paddr(paddr),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.dac_rdy(dac_rdy),
		.dac_batch(dac_batch),
		.dac_valid(dac_valid)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic take_rand_bit();
		rng_state = lfsr32_next(rng_state);
		return rng_state[0];
	endfunction

	function automatic int total_errors();
		return err_count + chk_errs;
	endfunction

	task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] want);
		check_count++;
		assert (got === want) else begin
			$display("ERROR %0t: %s expected %h got %h", $time, what, want, got);
			err_count++;
		end
	endtask

	// Setup phase, then access phase; prdata and pslverr are valid in the access phase.
	task automatic apb_access(input dac_gen_pkg::apb_addr_t addr, input logic write,
		input dac_gen_pkg::apb_data_t data, output dac_gen_pkg::apb_data_t rdata,
		output logic err);
		@(negedge clk);
		paddr = addr;
		pwrite = write;
		pwdata = data;
		psel = 1'b1;
		penable = 1'b0;
		@(negedge clk);
		penable = 1'b1;
		rdata = prdata;
		err = pslverr;
		check_eq("pready in the access phase", 32'(pready), 32'h1);
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic write_reg(input dac_gen_pkg::apb_addr_t addr, input dac_gen_pkg::apb_data_t data);
		dac_gen_pkg::apb_data_t rdata;
		logic err;
		apb_access(addr, 1'b1, data, rdata, err);
		check_eq($sformatf("pslverr on write to %h", addr), 32'(err), 32'h0);
	endtask

	task automatic read_check(input dac_gen_pkg::apb_addr_t addr, input dac_gen_pkg::apb_data_t want);
		dac_gen_pkg::apb_data_t rdata;
		logic err;
		apb_access(addr, 1'b0, 32'h0, rdata, err);
		check_eq($sformatf("pslverr on read of %h", addr), 32'(err), 32'h0);
		check_eq($sformatf("read of %h", addr), rdata, want);
	endtask

	// Waits out the restart edge before the stream starts.
	task automatic start_mode(input dac_gen_pkg::mode_t mode);
		write_reg(dac_gen_pkg::REG_CTRL, 32'(mode));
		@(negedge clk);
	endtask

	task automatic stream_batches(input logic stall);
		check_en = 1'b1;
		while (exp_q.size() != 0) begin
			dac_rdy = stall ? take_rand_bit() : 1'b1;
			@(negedge clk);
		end
		dac_rdy = 1'b0;
		check_en = 1'b0;
	endtask

	task automatic finish_test(input string name);
		int errs;
		errs = total_errors() - test_err_start;
		if (errs == 0) begin
			tests_passed++;
			$display("Test %s: PASS", name);
		end else begin
			tests_failed++;
			$display("Test %s: FAIL with %0d errors", name, errs);
		end
		test_err_start = total_errors();
	endtask

	always @(posedge clk) begin
		batch_t want;
		if (check_en) begin
			if (hold_pending) begin
				assert (dac_valid === held_valid && (!held_valid || dac_batch === held_batch))
				else begin
					$display("ERROR %0t: DAC outputs changed while dac_rdy was low", $time);
					chk_errs++;
				end
			end
			if (dac_valid && dac_rdy) begin
				if (exp_q.size() == 0) begin
					$display("A batch was accepted at time %0t when none was expected", $time);
					chk_errs++;
				end else begin
					want = exp_q.pop_front();
					chk_count++;
					assert (dac_batch === want) else begin
						$display("ERROR %0t: batch expected %h got %h", $time, want, dac_batch);
						chk_errs++;
					end
				end
			end
			hold_pending = !dac_rdy;
			held_valid = dac_valid;
			held_batch = dac_batch;
		end else begin
			hold_pending = 1'b0;
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Something failed");
		$finish;
	end

	initial begin
		dac_gen_pkg::apb_data_t rdata;
		logic err;
		batch_t seeds;
		int edges;
		logic r;
		rst_n = 1'b0;
		paddr = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		pwdata = '0;
		dac_rdy = 1'b0;
		check_en = 1'b0;
		hold_pending = 1'b0;
		rng_state = 32'h5710;
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		check_eq("dac_valid after reset", 32'(dac_valid), 32'h0);
		check_eq("prdata after reset", prdata, 32'h0);
		check_eq("pslverr after reset", 32'(pslverr), 32'h0);
		read_check(dac_gen_pkg::REG_CTRL, 32'h0);
		read_check(dac_gen_pkg::REG_SEED0, 32'h0);
		write_reg(dac_gen_pkg::REG_TRI_STEP, 32'h0000_1234);
		read_check(dac_gen_pkg::REG_TRI_STEP, 32'h0000_1234);
		for (int i = 0; i < LANES; i++) begin
			write_reg(8'(dac_gen_pkg::REG_SEED0 + 4 * i), 32'(16'h5A01 + 16'h1111 * i));
			read_check(8'(dac_gen_pkg::REG_SEED0 + 4 * i), 32'(16'h5A01 + 16'h1111 * i));
		end
		write_reg(dac_gen_pkg::REG_PWL_COUNT, 32'h5);
		read_check(dac_gen_pkg::REG_PWL_COUNT, 32'h5);
		apb_access(8'h20, 1'b0, 32'h0, rdata, err); // Hole in the map.
		check_eq("pslverr on unmapped read", 32'(err), 32'h1);
		apb_access(dac_gen_pkg::REG_STATUS, 1'b1, 32'h1, rdata, err);
		check_eq("pslverr on STATUS write", 32'(err), 32'h1);
		finish_test("register access");

		seeds = {16'hFFFF, 16'h1234, 16'h0000, 16'hACE1}; // Lane 3 down to lane 0.
		for (int i = 0; i < LANES; i++) begin
			write_reg(8'(dac_gen_pkg::REG_SEED0 + 4 * i), 32'(seeds[i]));
		end
		for (int k = 0; k < N_RAND; k++) begin
			exp_q.push_back(ref_lfsr_batch(seeds, k));
		end
		start_mode(dac_gen_pkg::MODE_RAND);
		stream_batches(1'b0);
		finish_test("random mode");

		write_reg(dac_gen_pkg::REG_TRI_STEP, 32'h0000_0900);
		for (int k = 0; k < N_TRI; k++) begin
			exp_q.push_back(ref_tri_batch(16'h0900, k));
		end
		start_mode(dac_gen_pkg::MODE_TRI);
		stream_batches(1'b0);
		finish_test("triangle mode");

		pwl_start[0] = 16'h1000;
		pwl_slope[0] = 16'h0100;
		pwl_len[0] = 16'd5;
		pwl_start[1] = 16'h2000;
		pwl_slope[1] = 16'hFE00; // Falling.
		pwl_len[1] = 16'd3;
		pwl_start[2] = 16'h0800;
		pwl_slope[2] = 16'h0000;
		pwl_len[2] = 16'd1;
		pwl_cnt = 2;
		for (int s = 0; s <= pwl_cnt; s++) begin
			write_reg(8'(dac_gen_pkg::REG_PWL_BASE + 8 * s), {pwl_slope[s], pwl_start[s]});
			write_reg(8'(dac_gen_pkg::REG_PWL_BASE + 8 * s + 4), 32'(pwl_len[s]));
		end
		write_reg(dac_gen_pkg::REG_PWL_COUNT, 32'(pwl_cnt));
		for (int k = 0; k < N_PWL; k++) begin
			exp_q.push_back(ref_pwl_batch(k));
		end
		start_mode(dac_gen_pkg::MODE_PWL);
		stream_batches(1'b0);
		// Generator runs PIPE_DEPTH batches ahead of the DAC.
		read_check(dac_gen_pkg::REG_STATUS,
			(32'(ref_pwl_seg(LANES * (N_PWL + PIPE_DEPTH))) << 4) | 32'h1);
		finish_test("PWL mode");

		for (int k = 0; k < N_TRI; k++) begin
			exp_q.push_back(ref_tri_batch(16'h0900, k));
		end
		start_mode(dac_gen_pkg::MODE_TRI);
		stream_batches(1'b1);
		finish_test("back-pressure");

		for (int k = 0; k < N_RESTART; k++) begin
			exp_q.push_back(ref_lfsr_batch(seeds, k));
		end
		start_mode(dac_gen_pkg::MODE_RAND);
		stream_batches(1'b0);
		dac_rdy = 1'b1; // Batches in flight are dropped by the restart.
		for (int k = 0; k < N_RESTART; k++) begin
			exp_q.push_back(ref_lfsr_batch(seeds, k));
		end
		start_mode(dac_gen_pkg::MODE_RAND);
		stream_batches(1'b0);
		write_reg(dac_gen_pkg::REG_CTRL, 32'(dac_gen_pkg::MODE_OFF));
		read_check(dac_gen_pkg::REG_STATUS, 32'h0);
		edges = 0;
		while (edges < PIPE_DEPTH + 2) begin
			check_eq($sformatf("dac_valid %0d enabled edges after OFF", edges),
				32'(dac_valid), 32'(edges < PIPE_DEPTH));
			r = take_rand_bit();
			dac_rdy = r;
			@(negedge clk);
			if (r) begin
				edges++;
			end
		end
		check_eq("dac_valid after the pipe drained", 32'(dac_valid), 32'h0);
		dac_rdy = 1'b0;
		finish_test("restart and off");

		$display("%0d tests passed, %0d failed, %0d checks, %0d errors",
			tests_passed, tests_failed, check_count + chk_count, total_errors());
		if (total_errors() == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- source/dac_sample_gen.sv
`default_nettype none

module dac_sample_gen #(
	parameter int NUM_LANES = dac_gen_pkg::LANES,
	parameter int SAMPLE_WIDTH = $bits(dac_gen_pkg::sample_t)
) (
	input wire clk,
	input wire rst_n,
	input wire dac_gen_pkg::apb_addr_t paddr,
	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire dac_gen_pkg::apb_data_t pwdata,
	output dac_gen_pkg::apb_data_t prdata,
	output logic pready,
	output logic pslverr,
	input wire dac_rdy,
	output dac_gen_pkg::sample_t [NUM_LANES-1:0] dac_batch,
	output logic dac_valid
);
	dac_gen_pkg::sample_t [NUM_LANES-1:0] rand_batch;
	dac_gen_pkg::sample_t [NUM_LANES-1:0] tri_batch;
	dac_gen_pkg::sample_t [NUM_LANES-1:0] pwl_batch;
	logic gen_step;
	logic rand_step;
	logic tri_step_en;
	logic pwl_step;

	dac_gen_if #(.NUM_LANES(NUM_LANES)) cfg_bus ();

	dac_cfg_regs #(.NUM_LANES(NUM_LANES)) regs_inst (
		.clk(clk),
		.rst_n(rst_n),
		.paddr(paddr),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.cfg(cfg_bus.cfg)
	);

	// Only the selected generator advances.
	assign rand_step = gen_step & (cfg_bus.mode == dac_gen_pkg::MODE_RAND);
	assign tri_step_en = gen_step & (cfg_bus.mode == dac_gen_pkg::MODE_TRI);
	assign pwl_step = gen_step & (cfg_bus.mode == dac_gen_pkg::MODE_PWL);

	for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
		lane_lfsr #(.SAMPLE_WIDTH(SAMPLE_WIDTH)) lfsr_inst (
			.clk(clk),
			.rst_n(rst_n),
			.load(cfg_bus.restart),
			.seed(cfg_bus.seeds[i]),
			.step(rand_step),
			.sample(rand_batch[i])
		);
	end

	tri_wave_gen #(.NUM_LANES(NUM_LANES)) tri_inst (
		.clk(clk),
		.rst_n(rst_n),
		.restart(cfg_bus.restart),
		.step(tri_step_en),
		.tri_step(cfg_bus.tri_step),
		.batch(tri_batch)
	);

	pwl_segment_gen #(.NUM_LANES(NUM_LANES)) pwl_inst (
		.clk(clk),
		.rst_n(rst_n),
		.gen(cfg_bus.gen),
		.step(pwl_step),
		.batch(pwl_batch)
	);

	batch_out_pipe #(.NUM_LANES(NUM_LANES)) pipe_inst (
		.clk(clk),
		.rst_n(rst_n),
		.gen(cfg_bus.gen),
		.dac_rdy(dac_rdy),
		.rand_batch(rand_batch),
		.tri_batch(tri_batch),
		.pwl_batch(pwl_batch),
		.dac_batch(dac_batch),
		.dac_valid(dac_valid),
		.gen_step(gen_step)
	);

endmodule

`default_nettype wire

//--- source/batch_out_pipe.sv
`default_nettype none

module batch_out_pipe #(
	parameter int NUM_LANES = dac_gen_pkg::LANES
) (
	input wire clk,
	input wire rst_n,
	dac_gen_if.gen gen,
	input wire dac_rdy,
	input wire dac_gen_pkg::sample_t [NUM_LANES-1:0] rand_batch,
	input wire dac_gen_pkg::sample_t [NUM_LANES-1:0] tri_batch,
	input wire dac_gen_pkg::sample_t [NUM_LANES-1:0] pwl_batch,
	output dac_gen_pkg::sample_t [NUM_LANES-1:0] dac_batch,
	output logic dac_valid,
	output logic gen_step
);
	localparam int STAGES = 3;

	dac_gen_pkg::sample_t [NUM_LANES-1:0] sel_batch;
	dac_gen_pkg::sample_t [NUM_LANES-1:0] stage_data [STAGES];
	logic [STAGES-1:0] stage_valid;
	logic active;

	assign active = gen.mode != dac_gen_pkg::MODE_OFF;
	assign gen_step = dac_rdy & active;

	always_comb begin
		case (gen.mode)
			dac_gen_pkg::MODE_RAND: sel_batch = rand_batch;
			dac_gen_pkg::MODE_TRI: sel_batch = tri_batch;
			dac_gen_pkg::MODE_PWL: sel_batch = pwl_batch;
			default: sel_batch = '0;
		endcase
	end

	// In OFF the pipe drains, otherwise a restart flushes it.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			stage_valid <= '0;
		end else if (gen.restart && active) begin
			stage_valid <= '0;
		end else if (dac_rdy) begin
			stage_valid <= {stage_valid[STAGES-2:0], active};
		end
	end

	always_ff @(posedge clk) begin
		if (dac_rdy) begin
			stage_data[0] <= sel_batch;
			for (int s = 1; s < STAGES; s++) begin
				stage_data[s] <= stage_data[s-1];
			end
		end
	end

	assign dac_batch = stage_data[STAGES-1];
	assign dac_valid = stage_valid[STAGES-1];

endmodule

`default_nettype wire

//--- source/pwl_segment_gen.sv
`default_nettype none

module pwl_segment_gen #(
	parameter int NUM_LANES = dac_gen_pkg::LANES
) (
	input wire clk,
	input wire rst_n,
	dac_gen_if.gen gen,
	input wire step,
	output dac_gen_pkg::sample_t [NUM_LANES-1:0] batch
);
	localparam int SEGS = dac_gen_pkg::PWL_SEGS;

	dac_gen_pkg::sample_t seg_start [SEGS];
	dac_gen_pkg::sample_t seg_slope [SEGS];
	dac_gen_pkg::seg_len_t seg_len [SEGS];
	dac_gen_pkg::seg_idx_t tbl_idx;

	dac_gen_pkg::pwl_state_e state;
	dac_gen_pkg::seg_idx_t seg;
	dac_gen_pkg::seg_len_t offset;
	dac_gen_pkg::sample_t value;

	dac_gen_pkg::seg_idx_t walk_seg;
	dac_gen_pkg::seg_len_t walk_off;
	dac_gen_pkg::seg_len_t walk_last;
	dac_gen_pkg::sample_t walk_val;

	assign tbl_idx = gen.tbl_addr[5:3];
	assign gen.pwl_seg = seg;

	// Word 0 holds start and slope, word 1 the length.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int s = 0; s < SEGS; s++) begin
				seg_start[s] <= '0;
				seg_slope[s] <= '0;
				seg_len[s] <= '0;
			end
		end else if (gen.tbl_we) begin
			if (gen.tbl_addr[2]) begin
				seg_len[tbl_idx] <= gen.tbl_data[15:0];
			end else begin
				seg_start[tbl_idx] <= gen.tbl_data[15:0];
				seg_slope[tbl_idx] <= gen.tbl_data[31:16];
			end
		end
	end

	// Walk one sample per lane.
	always_comb begin
		walk_seg = seg;
		walk_off = offset;
		walk_val = value;
		walk_last = '0;
		for (int i = 0; i < NUM_LANES; i++) begin
			batch[i] = (state == dac_gen_pkg::PWL_RUN) ? walk_val : '0;
			walk_last = (seg_len[walk_seg] == '0) ? '0 : seg_len[walk_seg] - 1'b1;
			if (walk_off >= walk_last) begin
				walk_seg = (walk_seg >= gen.pwl_count) ? '0 : walk_seg + 1'b1;
				walk_off = '0;
				walk_val = seg_start[walk_seg];
			end else begin
				walk_off = walk_off + 1'b1;
				walk_val = walk_val + seg_slope[walk_seg]; // Wraps mod 2^16.
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= dac_gen_pkg::PWL_IDLE;
			seg <= '0;
			offset <= '0;
			value <= '0;
		end else if (gen.restart) begin
			state <= dac_gen_pkg::PWL_RUN;
			seg <= '0;
			offset <= '0;
			value <= seg_start[0];
		end else if (step && state == dac_gen_pkg::PWL_RUN) begin
			seg <= walk_seg;
			offset <= walk_off;
			value <= walk_val;
		end
	end

endmodule

`default_nettype wire

//--- source/tri_wave_gen.sv
`default_nettype none

module tri_wave_gen #(
	parameter int NUM_LANES = dac_gen_pkg::LANES
) (
	input wire clk,
	input wire rst_n,
	input wire restart,
	input wire step,
	input wire dac_gen_pkg::sample_t tri_step,
	output dac_gen_pkg::sample_t [NUM_LANES-1:0] batch
);
	localparam int MSB = $bits(dac_gen_pkg::sample_t) - 1;

	dac_gen_pkg::sample_t phase;
	dac_gen_pkg::sample_t batch_adv;
	dac_gen_pkg::sample_t lane_phase [NUM_LANES];

	assign batch_adv = dac_gen_pkg::sample_t'(NUM_LANES) * tri_step;

	// Top bit of the phase picks the falling half.
	always_comb begin
		for (int i = 0; i < NUM_LANES; i++) begin
			lane_phase[i] = phase + dac_gen_pkg::sample_t'(i) * tri_step;
			if (lane_phase[i][MSB]) begin
				batch[i] = ~{lane_phase[i][MSB-1:0], 1'b0};
			end else begin
				batch[i] = {lane_phase[i][MSB-1:0], 1'b0};
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			phase <= '0;
		end else if (restart) begin
			phase <= '0;
		end else if (step) begin
			phase <= phase + batch_adv;
		end
	end

endmodule

`default_nettype wire

//--- source/lane_lfsr.sv
`default_nettype none

module lane_lfsr #(
	parameter int SAMPLE_WIDTH = 16
) (
	input wire clk,
	input wire rst_n,
	input wire load,
	input wire [SAMPLE_WIDTH-1:0] seed,
	input wire step,
	output logic [SAMPLE_WIDTH-1:0] sample
);
	localparam logic [SAMPLE_WIDTH-1:0] ONE = {{(SAMPLE_WIDTH-1){1'b0}}, 1'b1};

	logic [SAMPLE_WIDTH-1:0] state;
	logic feedback;

	// Taps 16, 14, 13, 11.
	assign feedback = state[SAMPLE_WIDTH-1] ^ state[SAMPLE_WIDTH-3]
		^ state[SAMPLE_WIDTH-4] ^ state[SAMPLE_WIDTH-6];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= ONE;
		end else if (load) begin
			state <= (seed == '0) ? ONE : seed; // Zero would lock up.
		end else if (step) begin
			state <= {state[SAMPLE_WIDTH-2:0], feedback};
		end
	end

	assign sample = state; // Value before the step.

endmodule

`default_nettype wire

//--- source/dac_cfg_regs.sv
`default_nettype none

module dac_cfg_regs #(
	parameter int NUM_LANES = dac_gen_pkg::LANES
) (
	input wire clk,
	input wire rst_n,
	input wire dac_gen_pkg::apb_addr_t paddr,
	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire dac_gen_pkg::apb_data_t pwdata,
	output dac_gen_pkg::apb_data_t prdata,
	output logic pready,
	output logic pslverr,
	dac_gen_if.cfg cfg
);
	logic setup;
	logic wr;
	logic is_ctrl;
	logic is_status;
	logic is_step;
	logic is_count;
	logic is_seed;
	logic is_tbl;
	logic mapped;
	logic acc_err;
	logic [1:0] seed_idx;
	dac_gen_pkg::apb_data_t rd_data;

	assign pready = 1'b1; // No wait states.
	assign setup = psel & ~penable;
	assign seed_idx = paddr[3:2];

	assign is_ctrl = paddr == dac_gen_pkg::REG_CTRL;
	assign is_status = paddr == dac_gen_pkg::REG_STATUS;
	assign is_step = paddr == dac_gen_pkg::REG_TRI_STEP;
	assign is_count = paddr == dac_gen_pkg::REG_PWL_COUNT;
	assign is_seed = (paddr inside {dac_gen_pkg::REG_SEED0, dac_gen_pkg::REG_SEED1,
		dac_gen_pkg::REG_SEED2, dac_gen_pkg::REG_SEED3}) && (int'(seed_idx) < NUM_LANES);
	assign is_tbl = (paddr[7:6] == 2'b01) && (paddr[1:0] == 2'b00); // 0x40 to 0x7C.

	assign mapped = is_ctrl | is_status | is_step | is_count | is_seed | is_tbl;
	assign acc_err = ~mapped | (pwrite & is_status);
	assign wr = psel & penable & pwrite & ~acc_err;

	// Table words are write only and read back as zero.
	always_comb begin
		rd_data = '0;
		if (is_ctrl) begin
			rd_data[1:0] = cfg.mode;
		end else if (is_status) begin
			rd_data[0] = cfg.mode != dac_gen_pkg::MODE_OFF;
			rd_data[6:4] = cfg.pwl_seg;
		end else if (is_step) begin
			rd_data[15:0] = cfg.tri_step;
		end else if (is_count) begin
			rd_data[2:0] = cfg.pwl_count;
		end else if (is_seed) begin
			rd_data[15:0] = cfg.seeds[seed_idx];
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			prdata <= '0;
			pslverr <= 1'b0;
			cfg.mode <= dac_gen_pkg::MODE_OFF;
			cfg.restart <= 1'b0;
			cfg.seeds <= '0;
			cfg.tri_step <= '0;
			cfg.pwl_count <= '0;
			cfg.tbl_we <= 1'b0;
		end else begin
			prdata <= (setup & ~pwrite) ? rd_data : '0; // Valid in the access phase.
			pslverr <= setup & acc_err;
			cfg.restart <= wr & is_ctrl;
			cfg.tbl_we <= wr & is_tbl;
			if (wr & is_ctrl) begin
				cfg.mode <= pwdata[1:0];
			end
			if (wr & is_step) begin
				cfg.tri_step <= pwdata[15:0];
			end
			if (wr & is_count) begin
				cfg.pwl_count <= pwdata[2:0];
			end
			if (wr & is_seed) begin
				cfg.seeds[seed_idx] <= pwdata[15:0];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr & is_tbl) begin
			cfg.tbl_addr <= paddr - dac_gen_pkg::REG_PWL_BASE;
			cfg.tbl_data <= pwdata;
		end
	end

endmodule

`default_nettype wire

//--- source/dac_gen_if.sv
`default_nettype none

interface dac_gen_if #(
	parameter int NUM_LANES = dac_gen_pkg::LANES
);
	dac_gen_pkg::mode_t mode;
	logic restart; // One cycle per CTRL write.
	dac_gen_pkg::sample_t [NUM_LANES-1:0] seeds;
	dac_gen_pkg::sample_t tri_step;
	dac_gen_pkg::seg_idx_t pwl_count;
	logic tbl_we;
	dac_gen_pkg::apb_addr_t tbl_addr; // Byte offset inside the table.
	dac_gen_pkg::apb_data_t tbl_data;
	dac_gen_pkg::seg_idx_t pwl_seg; // Back from the PWL walker.

	modport cfg (
		output mode, restart, seeds, tri_step, pwl_count,
		output tbl_we, tbl_addr, tbl_data,
		input pwl_seg
	);

	modport gen (
		input mode, restart, seeds, tri_step, pwl_count,
		input tbl_we, tbl_addr, tbl_data,
		output pwl_seg
	);

endinterface

`default_nettype wire

//--- source/dac_gen_pkg.sv
`default_nettype none

package dac_gen_pkg;

	typedef logic [15:0] sample_t;

	localparam int LANES = 4; // Samples per batch.
	localparam int PWL_SEGS = 8;

	typedef logic [1:0] mode_t;

	localparam mode_t MODE_OFF = 2'd0;
	localparam mode_t MODE_RAND = 2'd1;
	localparam mode_t MODE_TRI = 2'd2;
	localparam mode_t MODE_PWL = 2'd3;

	typedef logic [2:0] seg_idx_t;
	typedef logic [15:0] seg_len_t;
	typedef logic [7:0] apb_addr_t;
	typedef logic [31:0] apb_data_t;

	localparam apb_addr_t REG_CTRL = 8'h00;
	localparam apb_addr_t REG_STATUS = 8'h04;
	localparam apb_addr_t REG_TRI_STEP = 8'h08;
	localparam apb_addr_t REG_PWL_COUNT = 8'h0C;
	localparam apb_addr_t REG_SEED0 = 8'h10;
	localparam apb_addr_t REG_SEED1 = 8'h14;
	localparam apb_addr_t REG_SEED2 = 8'h18;
	localparam apb_addr_t REG_SEED3 = 8'h1C;
	localparam apb_addr_t REG_PWL_BASE = 8'h40; // Two words per segment.

	typedef enum logic {
		PWL_IDLE,
		PWL_RUN
	} pwl_state_e;

endpackage

`default_nettype wire
